// ==== include/csr_settings.svh ====
// Constants of the machine-mode CSR file: CSR addresses, the synchronous
// trap cause codes, the mtvec reset value and the ID values.
// Included by every RTL module that decodes addresses or holds constants.
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// ---------------------------------------------------------------------
// CSR addresses
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MISA       12'h301
`define CSR_ADDR_MEDELEG    12'h302
`define CSR_ADDR_MIDELEG    12'h303
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MCOUNTIN   12'h320
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MTVAL      12'h343
`define CSR_ADDR_MIP        12'h344
`define CSR_ADDR_MCYCLE     12'hB00
`define CSR_ADDR_MINSTRET   12'hB02
`define CSR_ADDR_MCYCLEH    12'hB80
`define CSR_ADDR_MINSTRETH  12'hB82
`define CSR_ADDR_CYCLE      12'hC00
`define CSR_ADDR_INSTRET    12'hC02
`define CSR_ADDR_CYCLEH     12'hC80
`define CSR_ADDR_INSTRETH   12'hC82
`define CSR_ADDR_MVENDORID  12'hF11
`define CSR_ADDR_MARCHID    12'hF12
`define CSR_ADDR_MIMPID     12'hF13
`define CSR_ADDR_MHARTID    12'hF14

// ---------------------------------------------------------------------
// Synchronous trap causes
`define TRAP_IALIGN         6'd0
`define TRAP_IACCESS        6'd1
`define TRAP_IOPCODE        6'd2
`define TRAP_BREAKPT        6'd3
`define TRAP_LDALIGN        6'd4
`define TRAP_LDACCESS       6'd5
`define TRAP_STALIGN        6'd6
`define TRAP_STACCESS       6'd7
`define TRAP_ECALLM         6'd11

// ---------------------------------------------------------------------
// Reset and ID values
`define CSR_MTVEC_RESET     32'hC000_0000
`define CSR_MISA_VALUE      32'h4080_1106   // MXL=1, extensions X M I C B
`define CSR_MVENDORID       32'h0000_0000
`define CSR_MARCHID         32'h0000_0000
`define CSR_MIMPID          32'h0000_0000
`define CSR_MHARTID         32'h0000_0000

`endif

// ==== rtl/csr_pkg.sv ====
// Vector types shared by the CSR file RTL.
// Imported by wildcard into the modules that carry these widths.
`default_nettype none

package csr_pkg;

    // Register and data word
    typedef logic [31:0] xlen_t;

    // CSR address field of the SYSTEM opcode
    typedef logic [11:0] csr_addr_t;

    // Full width of cycle and instret
    typedef logic [63:0] counter_t;

    // Exception or interrupt code, without the interrupt flag
    typedef logic [5:0]  trap_cause_t;

endpackage

`default_nettype wire

// ==== rtl/csr_access_if.sv ====
// One CSR access as issued by the core: enable, write kind, address and
// write data. Driven by the CSR file top, sampled by the register modules.
`default_nettype none

interface csr_access_if;

    logic              en;      // Access present this cycle
    logic              wr;      // Access writes
    logic              wr_set;  // OR wdata into register
    logic              wr_clr;  // Clear bits set in wdata
    csr_pkg::csr_addr_t addr;
    csr_pkg::xlen_t     wdata;

    modport source (output en, wr, wr_set, wr_clr, addr, wdata);
    modport sink   (input  en, wr, wr_set, wr_clr, addr, wdata);

endinterface

`default_nettype wire

// ==== rtl/csr_trap_regs.sv ====
// Machine trap registers: mstatus, mie, mtvec, mscratch, mepc, mcause, mtval.
// Every CSR write applies the write, set or clear rule to the current value.
// Trap entry and mret win over a CSR write in the same cycle.
`default_nettype none
`include "csr_settings.svh"

module csr_trap_regs
    import csr_pkg::*;
(
    input  logic          g_clk,
    input  logic          g_resetn,
    csr_access_if.sink    acc,
    input  logic          exec_mret,
    input  logic          trap_cpu,
    input  logic          trap_int,
    input  trap_cause_t   trap_cause,
    input  xlen_t         trap_mtval,
    input  xlen_t         trap_pc,
    output xlen_t         mstatus_word,
    output xlen_t         mie_word,
    output xlen_t         mtvec_word,
    output xlen_t         mscratch_word,
    output xlen_t         mepc_word,
    output xlen_t         mcause_word,
    output xlen_t         mtval_word,
    output logic          mtvec_bad_write,
    output logic          mstatus_mie,
    output logic          mie_meie,
    output logic          mie_mtie,
    output logic          mie_msie,
    output logic          vector_intrs
);

    function automatic xlen_t apply_write(input xlen_t cur, input xlen_t wd,
                                          input logic set, input logic clr);
        if (set)
            return cur | wd;
        else if (clr)
            return cur & ~wd;
        return wd;
    endfunction

    logic  mstatus_mpie;
    logic  take_trap;
    logic  wr_go;
    logic  mcause_legal;
    xlen_t n_mstatus, n_mie, n_mtvec, n_mscratch, n_mepc, n_mcause, n_mtval;

    assign take_trap = trap_cpu || trap_int;
    assign wr_go     = acc.en && acc.wr;

    assign n_mstatus  = apply_write(mstatus_word,  acc.wdata, acc.wr_set, acc.wr_clr);
    assign n_mie      = apply_write(mie_word,      acc.wdata, acc.wr_set, acc.wr_clr);
    assign n_mtvec    = apply_write(mtvec_word,    acc.wdata, acc.wr_set, acc.wr_clr);
    assign n_mscratch = apply_write(mscratch_word, acc.wdata, acc.wr_set, acc.wr_clr);
    assign n_mepc     = apply_write(mepc_word,     acc.wdata, acc.wr_set, acc.wr_clr);
    assign n_mcause   = apply_write(mcause_word,   acc.wdata, acc.wr_set, acc.wr_clr);
    assign n_mtval    = apply_write(mtval_word,    acc.wdata, acc.wr_set, acc.wr_clr);

    assign mstatus_word = {24'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};
    assign mie_word     = {20'b0, mie_meie, 3'b0, mie_mtie, 3'b0, mie_msie, 3'b0};
    assign vector_intrs = mtvec_word[0];

    // Mode 2 and 3 reserved; vectored base must be 64 byte aligned
    assign mtvec_bad_write = wr_go && (acc.addr == `CSR_ADDR_MTVEC) &&
                             (n_mtvec[1] || (n_mtvec[0] && |n_mtvec[5:2]));

    assign mcause_legal = (n_mcause[31:6] == 26'b0) &&
                          (n_mcause[5:0] inside {`TRAP_IALIGN, `TRAP_IACCESS,
                                                 `TRAP_IOPCODE, `TRAP_BREAKPT,
                                                 `TRAP_LDALIGN, `TRAP_LDACCESS,
                                                 `TRAP_STALIGN, `TRAP_STACCESS,
                                                 `TRAP_ECALLM});

    // ---------------------------------------------------------------------
    // mstatus and mie

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
        end else if (take_trap) begin
            mstatus_mpie <= mstatus_mie;    // Stack the enable
            mstatus_mie  <= 1'b0;
        end else if (exec_mret) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b0;
        end else if (wr_go && acc.addr == `CSR_ADDR_MSTATUS) begin
            mstatus_mie  <= n_mstatus[3];
            mstatus_mpie <= n_mstatus[7];
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mie_meie <= 1'b0;
            mie_mtie <= 1'b0;
            mie_msie <= 1'b0;
        end else if (wr_go && acc.addr == `CSR_ADDR_MIE) begin
            mie_meie <= n_mie[11];
            mie_mtie <= n_mie[7];
            mie_msie <= n_mie[3];
        end
    end

    // ---------------------------------------------------------------------
    // mtvec and mscratch

    always_ff @(posedge g_clk) begin
        if (!g_resetn)
            mtvec_word <= `CSR_MTVEC_RESET;
        else if (wr_go && acc.addr == `CSR_ADDR_MTVEC && !mtvec_bad_write)
            mtvec_word <= n_mtvec;
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn)
            mscratch_word <= '0;
        else if (wr_go && acc.addr == `CSR_ADDR_MSCRATCH)
            mscratch_word <= n_mscratch;
    end

    // ---------------------------------------------------------------------
    // mepc, mcause and mtval

    always_ff @(posedge g_clk) begin
        if (!g_resetn)
            mepc_word <= '0;
        else if (take_trap)
            mepc_word <= {trap_pc[31:1], 1'b0};
        else if (wr_go && acc.addr == `CSR_ADDR_MEPC)
            mepc_word <= {n_mepc[31:1], 1'b0};  // IALIGN is 16 bit
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn)
            mcause_word <= '0;
        else if (take_trap)
            mcause_word <= {trap_int, 25'b0, trap_cause};
        else if (wr_go && acc.addr == `CSR_ADDR_MCAUSE && mcause_legal)
            mcause_word <= n_mcause;
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn)
            mtval_word <= '0;
        else if (trap_cpu)
            mtval_word <= trap_mtval;       // Interrupts leave it alone
        else if (wr_go && acc.addr == `CSR_ADDR_MTVAL)
            mtval_word <= n_mtval;
    end

endmodule

`default_nettype wire

// ==== rtl/csr_counters.sv ====
// Cycle and instret counters, 64 bits each, with the mcountinhibit CSR.
// The counters are read through csr_read_mux and are not writable.
`default_nettype none
`include "csr_settings.svh"

module csr_counters
    import csr_pkg::*;
(
    input  logic          g_clk,
    input  logic          g_resetn,
    csr_access_if.sink    acc,
    input  logic          instr_retired,
    output counter_t      cycle_count,
    output counter_t      instret_count,
    output xlen_t         mcountin_word
);

    logic inhibit_cy;
    logic inhibit_ir;
    logic wen_mcountin;

    assign wen_mcountin = acc.en && acc.wr && (acc.addr == `CSR_ADDR_MCOUNTIN);

    // Bit 1 (TM) has no counter behind it and reads zero
    assign mcountin_word = {29'b0, inhibit_ir, 1'b0, inhibit_cy};

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            inhibit_cy <= 1'b0;
            inhibit_ir <= 1'b0;
        end else if (wen_mcountin) begin
            inhibit_cy <= acc.wdata[0];     // Plain store, no set or clear
            inhibit_ir <= acc.wdata[2];
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn)
            cycle_count <= '0;
        else if (!inhibit_cy)
            cycle_count <= cycle_count + 64'd1;
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn)
            instret_count <= '0;
        else if (instr_retired && !inhibit_ir)
            instret_count <= instret_count + 64'd1;
    end

endmodule

`default_nettype wire

// ==== rtl/csr_read_mux.sv ====
// CSR address decode and read data selection, plus the read-only
// constants and mip. Purely combinational; also produces csr_error.
`default_nettype none
`include "csr_settings.svh"

module csr_read_mux
    import csr_pkg::*;
(
    csr_access_if.sink    acc,
    input  xlen_t         mstatus_word,
    input  xlen_t         mie_word,
    input  xlen_t         mtvec_word,
    input  xlen_t         mscratch_word,
    input  xlen_t         mepc_word,
    input  xlen_t         mcause_word,
    input  xlen_t         mtval_word,
    input  logic          mtvec_bad_write,
    input  logic          mip_meip,
    input  logic          mip_mtip,
    input  logic          mip_msip,
    input  counter_t      cycle_count,
    input  counter_t      instret_count,
    input  xlen_t         mcountin_word,
    output xlen_t         csr_rdata,
    output logic          csr_error
);

    localparam int NUM_CSR = 24;

    // Address of each entry, same order as csr_view below
    localparam csr_addr_t CSR_MAP [NUM_CSR] = '{
        `CSR_ADDR_MSTATUS,  `CSR_ADDR_MISA,      `CSR_ADDR_MEDELEG,  `CSR_ADDR_MIDELEG,
        `CSR_ADDR_MIE,      `CSR_ADDR_MTVEC,     `CSR_ADDR_MCOUNTIN, `CSR_ADDR_MSCRATCH,
        `CSR_ADDR_MEPC,     `CSR_ADDR_MCAUSE,    `CSR_ADDR_MTVAL,    `CSR_ADDR_MIP,
        `CSR_ADDR_MCYCLE,   `CSR_ADDR_MINSTRET,  `CSR_ADDR_MCYCLEH,  `CSR_ADDR_MINSTRETH,
        `CSR_ADDR_CYCLE,    `CSR_ADDR_INSTRET,   `CSR_ADDR_CYCLEH,   `CSR_ADDR_INSTRETH,
        `CSR_ADDR_MVENDORID, `CSR_ADDR_MARCHID,  `CSR_ADDR_MIMPID,   `CSR_ADDR_MHARTID
    };

    xlen_t           mip_word;
    xlen_t           csr_view [NUM_CSR];
    logic [NUM_CSR-1:0] rd_sel;

    assign mip_word = {20'b0, mip_meip, 3'b0, mip_mtip, 3'b0, mip_msip, 3'b0};

    assign csr_view = '{
        mstatus_word,           `CSR_MISA_VALUE,        32'b0,                  32'b0,
        mie_word,               mtvec_word,             mcountin_word,          mscratch_word,
        mepc_word,              mcause_word,            mtval_word,             mip_word,
        cycle_count[31:0],      instret_count[31:0],    cycle_count[63:32],     instret_count[63:32],
        cycle_count[31:0],      instret_count[31:0],    cycle_count[63:32],     instret_count[63:32],
        `CSR_MVENDORID,         `CSR_MARCHID,           `CSR_MIMPID,            `CSR_MHARTID
    };

    // ---------------------------------------------------------------------
    // One-hot decode and AND-OR select

    always_comb begin
        for (int i = 0; i < NUM_CSR; i++)
            rd_sel[i] = acc.en && (acc.addr == CSR_MAP[i]);
    end

    always_comb begin
        csr_rdata = '0;                     // Unknown address reads zero
        for (int i = 0; i < NUM_CSR; i++)
            csr_rdata = csr_rdata | ({32{rd_sel[i]}} & csr_view[i]);
    end

    assign csr_error = acc.en && ((acc.wr && !(|rd_sel)) || mtvec_bad_write);

endmodule

`default_nettype wire

// ==== rtl/csr_file.sv ====
// Top of the machine-mode CSR file. The core's CSR access port enters as
// plain signals and is carried to the register modules on csr_access_if.
// Reads return in the same cycle; writes and traps land on the next edge.
`default_nettype none

module csr_file
    import csr_pkg::*;
(
    input  logic          g_clk,
    input  logic          g_resetn,
    input  logic          csr_en,
    input  logic          csr_wr,
    input  logic          csr_wr_set,
    input  logic          csr_wr_clr,
    input  csr_addr_t     csr_addr,
    input  xlen_t         csr_wdata,
    output xlen_t         csr_rdata,
    output logic          csr_error,
    output xlen_t         csr_mepc,
    output xlen_t         csr_mtvec,
    output logic          vector_intrs,
    input  logic          exec_mret,
    output logic          mstatus_mie,
    output logic          mie_meie,
    output logic          mie_mtie,
    output logic          mie_msie,
    input  logic          mip_meip,
    input  logic          mip_mtip,
    input  logic          mip_msip,
    input  logic          instr_retired,
    input  logic          trap_cpu,
    input  logic          trap_int,
    input  trap_cause_t   trap_cause,
    input  xlen_t         trap_mtval,
    input  xlen_t         trap_pc
);

    csr_access_if acc ();

    xlen_t    mstatus_word, mie_word, mtvec_word, mscratch_word;
    xlen_t    mepc_word, mcause_word, mtval_word, mcountin_word;
    logic     mtvec_bad_write;
    counter_t cycle_count, instret_count;

    assign acc.en     = csr_en;
    assign acc.wr     = csr_wr;
    assign acc.wr_set = csr_wr_set;
    assign acc.wr_clr = csr_wr_clr;
    assign acc.addr   = csr_addr;
    assign acc.wdata  = csr_wdata;

    assign csr_mepc  = mepc_word;
    assign csr_mtvec = {mtvec_word[31:2], 2'b00};  // Base only, mode stripped

    csr_trap_regs u_trap_regs (
        .g_clk, .g_resetn, .acc(acc.sink),
        .exec_mret, .trap_cpu, .trap_int, .trap_cause, .trap_mtval, .trap_pc,
        .mstatus_word, .mie_word, .mtvec_word, .mscratch_word,
        .mepc_word, .mcause_word, .mtval_word, .mtvec_bad_write,
        .mstatus_mie, .mie_meie, .mie_mtie, .mie_msie, .vector_intrs
    );

    csr_counters u_counters (
        .g_clk, .g_resetn, .acc(acc.sink), .instr_retired,
        .cycle_count, .instret_count, .mcountin_word
    );

    csr_read_mux u_read_mux (
        .acc(acc.sink),
        .mstatus_word, .mie_word, .mtvec_word, .mscratch_word,
        .mepc_word, .mcause_word, .mtval_word, .mtvec_bad_write,
        .mip_meip, .mip_mtip, .mip_msip,
        .cycle_count, .instret_count, .mcountin_word,
        .csr_rdata, .csr_error
    );

endmodule

`default_nettype wire

// ==== testbench/csr_file_assert.sv ====
// Concurrent checks on the CSR file top level.
// Attached to csr_file by a bind in the testbench; each failure is counted.
`default_nettype none

module csr_file_assert (
    input logic        g_clk,
    input logic        g_resetn,
    input logic        csr_en,
    input logic        csr_wr,
    input logic        csr_error,
    input logic        trap_cpu,
    input logic        trap_int,
    input logic        mstatus_mie,
    input logic        vector_intrs,
    input logic [31:0] csr_mtvec
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned noacc_fails = 0;
    int unsigned trap_fails  = 0;
    int unsigned mtvec_fails = 0;

    // Error only during a write access
    error_needs_access: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(csr_en && csr_wr) |-> !csr_error)
    else begin
        $error("csr_error high without a write access");
        noacc_fails++;
    end

    // Trap entry clears the global enable
    trap_clears_mie: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (trap_cpu || trap_int) |=> !mstatus_mie)
    else begin
        $error("mstatus_mie still set one cycle after a trap");
        trap_fails++;
    end

    // Vectored table base is 64 byte aligned
    mtvec_base_only: assert property (@(posedge g_clk) disable iff (!g_resetn)
        vector_intrs |-> csr_mtvec[5:0] == 6'b000000)
    else begin
        $error("csr_mtvec base not aligned while vectored mode is on");
        mtvec_fails++;
    end

endmodule

`default_nettype wire

// ==== testbench/csr_file_tb.sv ====
// Testbench for the machine-mode CSR file. Reads the access sequence from
// testbench/csr_cases.txt, drives one case at a time and checks read data,
// error flag and the status outputs. Run from the project root.
`default_nettype none
`include "csr_settings.svh"

module csr_file_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam string CASE_FILE = "testbench/csr_cases.txt";

    logic        g_clk = 1'b0;
    logic        g_resetn;
    logic        csr_en;
    logic        csr_wr;
    logic        csr_wr_set;
    logic        csr_wr_clr;
    logic [11:0] csr_addr;
    logic [31:0] csr_wdata;
    logic [31:0] csr_rdata;
    logic        csr_error;
    logic [31:0] csr_mepc;
    logic [31:0] csr_mtvec;
    logic        vector_intrs;
    logic        exec_mret;
    logic        mstatus_mie;
    logic        mie_meie;
    logic        mie_mtie;
    logic        mie_msie;
    logic        mip_meip;
    logic        mip_mtip;
    logic        mip_msip;
    logic        instr_retired;
    logic        trap_cpu;
    logic        trap_int;
    logic [5:0]  trap_cause;
    logic [31:0] trap_mtval;
    logic [31:0] trap_pc;

    // Case table, one entry per line of the case file
    byte         op_q[$];
    logic [11:0] addr_q[$];
    logic [31:0] data_q[$];
    logic [31:0] exp_q[$];
    logic        err_q[$];

    int          value_errs = 0;
    int          other_errs = 0;
    int          cycles = 0;
    int          limit = 0;            // Set once the cases are read
    logic [31:0] retire_total = '0;    // Retire pulses driven so far

    csr_file DUT (.*);

    bind csr_file csr_file_assert u_assert (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .csr_en      (csr_en),
        .csr_wr      (csr_wr),
        .csr_error   (csr_error),
        .trap_cpu    (trap_cpu),
        .trap_int    (trap_int),
        .mstatus_mie (mstatus_mie),
        .vector_intrs (vector_intrs),
        .csr_mtvec   (csr_mtvec)
    );

    always #10 g_clk = ~g_clk;

    // ----------------------------------------------------------------------
    // Checks

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("ERR %0t %s got %08h expected %08h", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp)
        else begin
            $display("ERR %0t %s got %0b expected %0b", $time, name, got, exp);
            value_errs++;
        end
    endtask

    // Read data and error, plus the outputs that mirror the CSR read
    task automatic check_read(input logic [11:0] addr, input logic [31:0] exp,
                              input logic err);
        check_word("csr_rdata", csr_rdata, exp);
        check_bit("csr_error", csr_error, err);
        case (addr)
            `CSR_ADDR_MIE: begin
                check_bit("mie_meie", mie_meie, exp[11]);
                check_bit("mie_mtie", mie_mtie, exp[7]);
                check_bit("mie_msie", mie_msie, exp[3]);
            end
            `CSR_ADDR_MTVEC: begin
                check_bit("vector_intrs", vector_intrs, exp[0]);
                check_word("csr_mtvec", csr_mtvec, {exp[31:2], 2'b00});
            end
            `CSR_ADDR_MEPC:    check_word("csr_mepc", csr_mepc, exp);
            `CSR_ADDR_MSTATUS: check_bit("mstatus_mie", mstatus_mie, exp[3]);
            default: ;
        endcase
    endtask

    // ----------------------------------------------------------------------
    // Stimulus

    task automatic drive_idle();
        csr_en        <= 1'b0;
        csr_wr        <= 1'b0;
        csr_wr_set    <= 1'b0;
        csr_wr_clr    <= 1'b0;
        csr_addr      <= '0;
        csr_wdata     <= '0;
        exec_mret     <= 1'b0;
        mip_meip      <= 1'b0;
        mip_mtip      <= 1'b0;
        mip_msip      <= 1'b0;
        instr_retired <= 1'b0;
        trap_cpu      <= 1'b0;
        trap_int      <= 1'b0;
        trap_cause    <= '0;
        trap_mtval    <= '0;
        trap_pc       <= '0;
    endtask

    task automatic read_cases();
        int          fd;
        int          n;
        int          er;
        string       line;
        byte         op;
        logic [31:0] a, d, e;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the case file %s", CASE_FILE);
            other_errs++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h %h %d", op, a, d, e, er);
                if (n == 5) begin
                    op_q.push_back(op);
                    addr_q.push_back(a[11:0]);
                    data_q.push_back(d);
                    exp_q.push_back(e);
                    err_q.push_back(er[0]);
                end else begin
                    $display("Malformed line in the case file: %s", line);
                    other_errs++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_case(input int i);
        byte         op;
        logic [31:0] first;
        logic [31:0] second;
        op = op_q[i];
        @(posedge g_clk);
        drive_idle();
        case (op)
            "R": begin
                csr_en   <= 1'b1;
                csr_addr <= addr_q[i];
                mip_meip <= data_q[i][11];    // Pending inputs ride on data
                mip_mtip <= data_q[i][7];
                mip_msip <= data_q[i][3];
                @(negedge g_clk);
                check_read(addr_q[i], exp_q[i], err_q[i]);
            end
            "W", "S", "C": begin
                csr_en     <= 1'b1;
                csr_wr     <= 1'b1;
                csr_wr_set <= (op == "S");
                csr_wr_clr <= (op == "C");
                csr_addr   <= addr_q[i];
                csr_wdata  <= data_q[i];
                @(negedge g_clk);
                check_bit("csr_error", csr_error, err_q[i]);
            end
            "T", "I": begin
                trap_cpu   <= (op == "T");
                trap_int   <= (op == "I");
                trap_cause <= addr_q[i][5:0];
                trap_pc    <= data_q[i];
                trap_mtval <= exp_q[i];
            end
            "M": exec_mret <= 1'b1;
            "D": begin
                csr_en   <= 1'b1;          // Held while the counter runs
                csr_addr <= addr_q[i];
                @(negedge g_clk);
                first = csr_rdata;
                repeat (data_q[i]) @(negedge g_clk);
                second = csr_rdata;
                check_word("csr_rdata delta", second - first, exp_q[i]);
            end
            "P": begin
                repeat (data_q[i]) begin
                    instr_retired <= 1'b1;
                    retire_total++;
                    @(posedge g_clk);
                end
                drive_idle();
                csr_en   <= 1'b1;
                csr_addr <= addr_q[i];
                @(negedge g_clk);
                check_word("csr_rdata", csr_rdata, exp_q[i]);
                check_word("csr_rdata vs pulses", csr_rdata, retire_total);
            end
            default: begin
                $display("Unknown operation '%c' in case %0d", op, i);
                other_errs++;
            end
        endcase
    endtask

    // ----------------------------------------------------------------------
    // Run control

    function automatic int assert_errs();
        return DUT.u_assert.noacc_fails + DUT.u_assert.trap_fails +
               DUT.u_assert.mtvec_fails;
    endfunction

    task automatic report_counts();
        $display("Errors: %0d value, %0d assertion, %0d other",
                 value_errs, assert_errs(), other_errs);
    endtask

    initial begin
        g_resetn <= 1'b0;
        drive_idle();
        read_cases();
        limit = op_q.size() * 4 + 50;
        repeat (5) @(posedge g_clk);
        g_resetn <= 1'b1;
        for (int i = 0; i < op_q.size(); i++)
            run_case(i);
        @(posedge g_clk);
        drive_idle();
        @(posedge g_clk);                  // Last assertion samples
        report_counts();
        if (value_errs == 0 && other_errs == 0 && assert_errs() == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    always @(posedge g_clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout, the run did not finish within %0d cycles", limit);
            report_counts();
            $display("Checks failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/csr_cases.txt ====
# op addr data expected err; R read, W write, S set, C clear, M mret
# T cpu trap, I interrupt trap: addr is the cause, data the pc, expected the mtval
# D cycle delta over data cycles, P data retire pulses then instret read; R data drives mip
W 340 12345678 00000000 0
S 340 0000000F 00000000 0
C 340 12000000 00000000 0
R 340 00000000 0034567F 0
W 304 FFFFFFFF 00000000 0
C 304 00000080 00000000 0
R 304 00000000 00000808 0
W 305 00000002 00000000 1
W 305 80000005 00000000 1
R 305 00000000 C0000000 0
W 305 80000041 00000000 0
R 305 00000000 80000041 0
W 7C0 FFFFFFFF 00000000 1
R 7C0 00000000 00000000 0
S 300 00000008 00000000 0
T 002 00001003 DEADBEEF 0
R 341 00000000 00001002 0
R 342 00000000 00000002 0
R 343 00000000 DEADBEEF 0
R 300 00000000 00000080 0
M 000 00000000 00000000 0
I 007 00002000 11111111 0
R 342 00000000 80000007 0
R 343 00000000 DEADBEEF 0
R 341 00000000 00002000 0
M 000 00000000 00000000 0
R 300 00000000 00000008 0
W 342 0000000A 00000000 0
R 342 00000000 80000007 0
W 342 0000000B 00000000 0
R 342 00000000 0000000B 0
D C00 00000005 00000005 0
W 320 00000001 00000000 0
R 320 00000000 00000001 0
D C00 00000005 00000000 0
W 320 00000000 00000000 0
P C02 00000003 00000003 0
R B02 00000000 00000003 0
R 301 00000000 40801106 0
R F11 00000000 00000000 0
R F14 00000000 00000000 0
R 344 00000888 00000888 0
R 344 00000080 00000080 0

// ==== flist.f ====
+incdir+include
rtl/csr_pkg.sv
rtl/csr_access_if.sv
rtl/csr_trap_regs.sv
rtl/csr_counters.sv
rtl/csr_read_mux.sv
rtl/csr_file.sv
testbench/csr_file_assert.sv
testbench/csr_file_tb.sv

// ==== Makefile ====
# Verilator build and run of the CSR file testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := csr_file_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Checks failed
PASS_MSG  := All checks passed

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) +verilator+error+limit+1000 > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
